//--- dino_core.f
+incdir+.
dino_pkg.sv
uart_rx_16x.sv
cmd_decoder.sv
hitbox_check.sv
score_keeper.sv
seg7_score_display.sv
dino_core.sv
tb_clock_gen.sv
tb_dino_core.sv

//--- dino_stimulus.txt
# U byte_hex exp_jump exp_duck | P dino_x dino_y obs_x obs_y exp_collided exp_respawn
# R restart pulse | E score speed high_score collided | W cycles
U 4A 1 0
U 58 0 0
E 0 0 0 0
U 44 0 1
P 40 100 50 90 0 0
W 220
P 40 100 300 90 0 0
P 40 100 30 200 0 1
E 1 1 0 0
P 40 100 100 200 0 0
P 40 100 20 200 0 0
E 1 1 0 0
P 40 100 300 200 0 0
P 40 100 10 200 0 1
P 40 100 310 200 0 0
P 40 100 35 200 0 1
E 3 3 0 0
P 40 100 50 131 0 0
P 40 100 50 130 1 0
E 3 3 3 1
P 40 100 300 200 1 0
P 40 100 20 200 1 0
E 3 3 3 1
R
E 0 0 3 0
P 40 100 20 200 0 1
E 1 1 3 0

//--- tb_dino_core.sv
`timescale 1ns/1ns
`default_nettype none
`include "dino_cfg.svh"

module tb_dino_core import dino_pkg::*; ();

	localparam int DRIVE_DLY = 2;
	localparam int BIT_CLKS  = 16 * `OS_DIV; // Clocks per serial bit

	// Active-low digit patterns with digit 0 in the low bits
	localparam logic [69:0] SEG_PATTERNS = {
		7'b0010000, 7'b0000000, 7'b1111000, 7'b0000010, 7'b0010010,
		7'b0011001, 7'b0110000, 7'b0100100, 7'b1111001, 7'b1000000};

	logic     Clock, rst_n;
	logic     i_uart_rx, i_pos_valid, i_restart;
	coord_x_t i_dino_x, i_obs_x;
	coord_y_t i_dino_y, i_obs_y;
	logic     o_jump, o_ducking, o_collided, o_respawn;
	speed_t   o_speed;
	score_t   o_score, o_high_score;
	seg7_t    o_hex0, o_hex1, o_hex2, o_hex3, o_hex4, o_hex5;

	int       errors;
	int       jump_count;
	int       duck_len;
	int       cycle_count;
	int       cycle_limit;
	integer   seed;
	string    lines[$];

	tb_clock_gen u_clk (.o_clock(Clock), .o_rst_n(rst_n));

	dino_core dut0 (
		.Clock(Clock), .rst_n(rst_n), .i_uart_rx(i_uart_rx),
		.i_pos_valid(i_pos_valid), .i_restart(i_restart),
		.i_dino_x(i_dino_x), .i_dino_y(i_dino_y), .i_obs_x(i_obs_x), .i_obs_y(i_obs_y),
		.o_jump(o_jump), .o_ducking(o_ducking), .o_collided(o_collided),
		.o_respawn(o_respawn), .o_speed(o_speed), .o_score(o_score),
		.o_high_score(o_high_score), .o_hex0(o_hex0), .o_hex1(o_hex1),
		.o_hex2(o_hex2), .o_hex3(o_hex3), .o_hex4(o_hex4), .o_hex5(o_hex5)
	);

	function automatic seg7_t digit_pattern(input int d);
		return SEG_PATTERNS[d * 7 +: 7];
	endfunction

	task automatic report_error(input string msg);
		errors++;
		$display("ERROR at %0t ns: %s", $time, msg);
	endtask

	task automatic bad_stimulus(input string l);
		errors++;
		$display("Stimulus line could not be used: %s", l);
	endtask

	task automatic idle_gap();
		int n;
		n = $random(seed) & 3; // Zero to three spare cycles
		repeat (n) @(posedge Clock);
	endtask

	// 8N1 frame sent LSB first
	task automatic send_serial(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge Clock);
			#DRIVE_DLY i_uart_rx = frame[i];
			repeat (BIT_CLKS - 1) @(posedge Clock);
		end
	endtask

	task automatic check_digits(input int value, input seg7_t h0, h1, h2, input string name);
		if (h0 !== digit_pattern(value % 10) || h1 !== digit_pattern((value / 10) % 10) ||
			h2 !== digit_pattern((value / 100) % 10))
			report_error($sformatf("%s digits %b %b %b do not show %0d", name, h2, h1, h0, value));
	endtask

	// Result is visible two cycles after the strobe
	task automatic apply_sample(input int dx, dy, ox, oy, exp_coll, exp_resp);
		@(posedge Clock);
		#DRIVE_DLY;
		i_pos_valid = 1'b1;
		i_dino_x    = coord_x_t'(dx);
		i_dino_y    = coord_y_t'(dy);
		i_obs_x     = coord_x_t'(ox);
		i_obs_y     = coord_y_t'(oy);
		@(posedge Clock);
		#DRIVE_DLY i_pos_valid = 1'b0;
		@(posedge Clock);
		@(negedge Clock);
		if (o_collided !== exp_coll[0])
			report_error($sformatf("collided %b, expected %0d", o_collided, exp_coll));
		if (o_respawn !== exp_resp[0])
			report_error($sformatf("respawn %b, expected %0d", o_respawn, exp_resp));
	endtask

	task automatic check_state(input int exp_score, exp_speed, exp_high, exp_coll);
		@(negedge Clock);
		if (o_score !== score_t'(exp_score))
			report_error($sformatf("score %0d, expected %0d", o_score, exp_score));
		if (o_speed !== speed_t'(exp_speed))
			report_error($sformatf("speed %0d, expected %0d", o_speed, exp_speed));
		if (o_high_score !== score_t'(exp_high))
			report_error($sformatf("high score %0d, expected %0d", o_high_score, exp_high));
		if (o_collided !== exp_coll[0])
			report_error($sformatf("collided %b, expected %0d", o_collided, exp_coll));
		check_digits(exp_score, o_hex0, o_hex1, o_hex2, "score");
		check_digits(exp_high, o_hex3, o_hex4, o_hex5, "high score");
	endtask

	// Jump pulses and duck length are watched on every cycle
	always @(negedge Clock) begin
		if (rst_n) begin
			if (o_jump)
				jump_count++;
			if (o_ducking) begin
				duck_len++;
				if (duck_len == `DUCK_CYCLES + 1)
					report_error("ducking held past its length");
			end else if (duck_len != 0) begin
				if (duck_len != `DUCK_CYCLES)
					report_error($sformatf("duck lasted %0d cycles", duck_len));
				duck_len = 0;
			end
		end
	end

	always @(posedge Clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count > cycle_limit) begin
			$display("Run stopped, no progress within %0d clock cycles", cycle_limit);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	initial begin : stimulus_run
		int    fd;
		int    code;
		int    a1, a2, a3, a4, a5, a6;
		int    jumps_before;
		byte   c;
		string line;
		string rest;
		seed        = 4934;
		errors      = 0;
		jump_count  = 0;
		duck_len    = 0;
		cycle_count = 0;
		cycle_limit = 0;
		i_uart_rx   = 1'b1; // Line idles high
		i_pos_valid = 1'b0;
		i_restart   = 1'b0;
		i_dino_x    = '0;
		i_dino_y    = '0;
		i_obs_x     = '0;
		i_obs_y     = '0;

		fd = $fopen("dino_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Could not open dino_stimulus.txt");
			$display("STATUS: FAIL");
			$finish;
		end else begin
			while (!$feof(fd)) begin
				if ($fgets(line, fd) > 0) begin
					c = line.getc(0);
					if (c != "#" && c != "\n" && c != "\r" && c != " ")
						lines.push_back(line);
				end
			end
			$fclose(fd);

			// Budget from what each line costs plus reset and slack
			cycle_limit = 100;
			foreach (lines[i]) begin
				c = lines[i].getc(0);
				rest = lines[i].substr(1, lines[i].len() - 1);
				if (c == "U")
					cycle_limit += 10 * BIT_CLKS + 12;
				else if (c == "W" && $sscanf(rest, "%d", a1) == 1)
					cycle_limit += a1 + 6;
				else
					cycle_limit += 10;
			end

			wait (rst_n === 1'b1);
			foreach (lines[i]) begin
				c = lines[i].getc(0);
				rest = lines[i].substr(1, lines[i].len() - 1);
				idle_gap();
				case (c)
					"U": begin
						code = $sscanf(rest, "%h %d %d", a1, a2, a3);
						if (code != 3)
							bad_stimulus(lines[i]);
						jumps_before = jump_count;
						send_serial(a1[7:0]);
						repeat (2) @(posedge Clock);
						@(negedge Clock);
						if (jump_count - jumps_before != a2)
							report_error($sformatf("byte %h gave %0d jumps, expected %0d",
								a1[7:0], jump_count - jumps_before, a2));
						if (o_ducking !== a3[0])
							report_error($sformatf("byte %h left ducking %b", a1[7:0], o_ducking));
					end
					"P": begin
						code = $sscanf(rest, "%d %d %d %d %d %d", a1, a2, a3, a4, a5, a6);
						if (code != 6)
							bad_stimulus(lines[i]);
						apply_sample(a1, a2, a3, a4, a5, a6);
					end
					"R": begin
						@(posedge Clock);
						#DRIVE_DLY i_restart = 1'b1;
						@(posedge Clock);
						#DRIVE_DLY i_restart = 1'b0;
					end
					"E": begin
						code = $sscanf(rest, "%d %d %d %d", a1, a2, a3, a4);
						if (code != 4)
							bad_stimulus(lines[i]);
						check_state(a1, a2, a3, a4);
					end
					"W": begin
						code = $sscanf(rest, "%d", a1);
						if (code != 1)
							bad_stimulus(lines[i]);
						repeat (a1) @(posedge Clock);
					end
					default: begin
						bad_stimulus(lines[i]);
					end
				endcase
			end

			repeat (4) @(posedge Clock);
			$display("Run complete with %0d errors", errors);
			if (errors == 0)
				$display("STATUS: PASS");
			else
				$display("STATUS: FAIL");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD     = 40,
	parameter int RST_CYCLES = 2
) (
	output logic o_clock,
	output logic o_rst_n
);

	initial begin
		o_clock = 1'b0;
		forever #(PERIOD / 2) o_clock = ~o_clock;
	end

	// Reset low across the first rising edges, released just after one
	initial begin
		o_rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge o_clock);
		#2 o_rst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- dino_core.sv
`timescale 1ns/1ns
`default_nettype none

module dino_core import dino_pkg::*; (
	input  wire      Clock,
	input  wire      rst_n,
	input  wire      i_uart_rx,
	input  wire      i_pos_valid,
	input  wire      i_restart,
	input  coord_x_t i_dino_x,
	input  coord_y_t i_dino_y,
	input  coord_x_t i_obs_x,
	input  coord_y_t i_obs_y,
	output logic     o_jump,
	output logic     o_ducking,
	output logic     o_collided,
	output logic     o_respawn,
	output speed_t   o_speed,
	output score_t   o_score,
	output score_t   o_high_score,
	output seg7_t    o_hex0,
	output seg7_t    o_hex1,
	output seg7_t    o_hex2,
	output seg7_t    o_hex3,
	output seg7_t    o_hex4,
	output seg7_t    o_hex5
);

	logic     rx_valid;
	rx_byte_t rx_byte;
	logic     hit_valid, hit;
	coord_x_t hit_dino_x, hit_obs_x; // x positions of the checked sample

	uart_rx_16x u_rx (
		.Clock   (Clock),
		.rst_n   (rst_n),
		.i_rx    (i_uart_rx),
		.o_valid (rx_valid),
		.o_byte  (rx_byte)
	);

	cmd_decoder u_dec (
		.Clock     (Clock),
		.rst_n     (rst_n),
		.i_valid   (rx_valid),
		.i_byte    (rx_byte),
		.o_jump    (o_jump),
		.o_ducking (o_ducking)
	);

	hitbox_check u_hit (
		.Clock       (Clock),
		.rst_n       (rst_n),
		.i_pos_valid (i_pos_valid),
		.i_ducking   (o_ducking),
		.i_dino_x    (i_dino_x),
		.i_obs_x     (i_obs_x),
		.i_dino_y    (i_dino_y),
		.i_obs_y     (i_obs_y),
		.o_valid     (hit_valid),
		.o_hit       (hit),
		.o_dino_x    (hit_dino_x),
		.o_obs_x     (hit_obs_x)
	);

	score_keeper u_score (
		.Clock        (Clock),
		.rst_n        (rst_n),
		.i_restart    (i_restart),
		.i_valid      (hit_valid),
		.i_hit        (hit),
		.i_dino_x     (hit_dino_x),
		.i_obs_x      (hit_obs_x),
		.o_collided   (o_collided),
		.o_respawn    (o_respawn),
		.o_score      (o_score),
		.o_high_score (o_high_score),
		.o_speed      (o_speed)
	);

	seg7_score_display u_seg (
		.i_score      (o_score),
		.i_high_score (o_high_score),
		.o_hex0       (o_hex0),
		.o_hex1       (o_hex1),
		.o_hex2       (o_hex2),
		.o_hex3       (o_hex3),
		.o_hex4       (o_hex4),
		.o_hex5       (o_hex5)
	);

endmodule

`default_nettype wire

//--- seg7_score_display.sv
`timescale 1ns/1ns
`default_nettype none

module seg7_score_display import dino_pkg::*; (
	input  score_t i_score,
	input  score_t i_high_score,
	output seg7_t  o_hex0,
	output seg7_t  o_hex1,
	output seg7_t  o_hex2,
	output seg7_t  o_hex3,
	output seg7_t  o_hex4,
	output seg7_t  o_hex5
);

	digit_t s_ones, s_tens, s_hund;
	digit_t h_ones, h_tens, h_hund;

	// Active-low pattern, segment g on top
	function automatic seg7_t seg_encode(input digit_t d);
		case (d)
			4'd0:    return 7'b1000000;
			4'd1:    return 7'b1111001;
			4'd2:    return 7'b0100100;
			4'd3:    return 7'b0110000;
			4'd4:    return 7'b0011001;
			4'd5:    return 7'b0010010;
			4'd6:    return 7'b0000010;
			4'd7:    return 7'b1111000;
			4'd8:    return 7'b0000000;
			4'd9:    return 7'b0010000;
			default: return 7'b1111111; // Blank
		endcase
	endfunction

	// Three digits, so values show modulo 1000
	assign s_ones = digit_t'(i_score % 16'd10);
	assign s_tens = digit_t'((i_score / 16'd10) % 16'd10);
	assign s_hund = digit_t'((i_score / 16'd100) % 16'd10);

	assign h_ones = digit_t'(i_high_score % 16'd10);
	assign h_tens = digit_t'((i_high_score / 16'd10) % 16'd10);
	assign h_hund = digit_t'((i_high_score / 16'd100) % 16'd10);

	assign o_hex0 = seg_encode(s_ones);
	assign o_hex1 = seg_encode(s_tens);
	assign o_hex2 = seg_encode(s_hund);
	assign o_hex3 = seg_encode(h_ones);
	assign o_hex4 = seg_encode(h_tens);
	assign o_hex5 = seg_encode(h_hund);

endmodule

`default_nettype wire

//--- score_keeper.sv
`timescale 1ns/1ns
`default_nettype none
`include "dino_cfg.svh"

module score_keeper import dino_pkg::*; (
	input  wire      Clock,
	input  wire      rst_n,
	input  wire      i_restart,
	input  wire      i_valid,
	input  wire      i_hit,
	input  coord_x_t i_dino_x,
	input  coord_x_t i_obs_x,
	output logic     o_collided,
	output logic     o_respawn,
	output score_t   o_score,
	output score_t   o_high_score,
	output speed_t   o_speed
);

	coord_x_t prev_obs_x;
	logic     prev_hit;
	logic     passed;      // Crossing already counted for this lap
	logic     collided_q;
	logic     pass, rearm;

	assign pass  = (prev_obs_x > i_dino_x) && (i_obs_x <= i_dino_x) && !passed;
	assign rearm = (i_obs_x > coord_x_t'(`SCORE_REARM_HI)) &&
		(prev_obs_x < coord_x_t'(`SCORE_REARM_LO));

	always_ff @(posedge Clock) begin
		if (!rst_n || i_restart) begin
			o_collided <= 1'b0;
			o_respawn  <= 1'b0;
			o_score    <= '0;
			o_speed    <= '0;
			prev_obs_x <= coord_x_t'(`XSCREEN);
			prev_hit   <= 1'b0;
			passed     <= 1'b0;
		end else begin
			o_respawn <= 1'b0;
			if (i_valid) begin
				prev_obs_x <= i_obs_x;
				prev_hit   <= i_hit;
				if (!o_collided) begin
					if (pass) begin
						if (!i_hit && !prev_hit) begin // Clean jump over it
							o_score   <= o_score + 1'b1;
							o_speed   <= o_speed + 1'b1;
							o_respawn <= 1'b1;
						end
						passed <= 1'b1;
					end
					if (rearm)
						passed <= 1'b0; // Obstacle came around again
					if (i_hit)
						o_collided <= 1'b1;
				end
			end
		end
	end

	// High score survives restart
	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			collided_q   <= 1'b0;
			o_high_score <= '0;
		end else begin
			collided_q <= o_collided;
			if (o_collided && !collided_q && (o_score > o_high_score))
				o_high_score <= o_score;
		end
	end

	// No score after the game has ended
	a_no_score_latched: assert property (@(posedge Clock) disable iff (!rst_n)
		(o_score > $past(o_score)) |-> !$past(o_collided));

endmodule

`default_nettype wire

//--- hitbox_check.sv
`timescale 1ns/1ns
`default_nettype none
`include "dino_cfg.svh"

module hitbox_check import dino_pkg::*; (
	input  wire      Clock,
	input  wire      rst_n,
	input  wire      i_pos_valid,
	input  wire      i_ducking,
	input  coord_x_t i_dino_x,
	input  coord_x_t i_obs_x,
	input  coord_y_t i_dino_y,
	input  coord_y_t i_obs_y,
	output logic     o_valid,
	output logic     o_hit,
	output coord_x_t o_dino_x,
	output coord_x_t o_obs_x
);

	// Two spare bits so edge sums never wrap
	localparam int XW = $bits(coord_x_t) + 2;
	localparam int YW = $bits(coord_y_t) + 2;

	coord_y_t      dino_y_q, obs_y_q;
	logic          duck_q;
	logic [YW-1:0] top_ofs, height;
	logic [XW-1:0] d_left, d_right, o_left, o_right;
	logic [YW-1:0] d_top, d_bottom, o_top, o_bottom;

	always_ff @(posedge Clock) begin
		if (!rst_n)
			o_valid <= 1'b0;
		else
			o_valid <= i_pos_valid;
	end

	// Sample payload, held until the next strobe
	always_ff @(posedge Clock) begin
		if (i_pos_valid) begin
			o_dino_x <= i_dino_x;
			o_obs_x  <= i_obs_x;
			dino_y_q <= i_dino_y;
			obs_y_q  <= i_obs_y;
			duck_q   <= i_ducking; // Duck state at the strobe
		end
	end

	always_comb begin
		if (duck_q) begin
			top_ofs = YW'(`DINO_TOP_DUCK);
			height  = YW'(`DINO_H_DUCK);
		end else begin
			top_ofs = YW'(`DINO_TOP_STAND);
			height  = YW'(`DINO_H_STAND);
		end
	end

	assign d_left   = XW'(o_dino_x) + XW'(`DINO_X_OFS);
	assign d_right  = d_left + XW'(`DINO_W);
	assign d_top    = YW'(dino_y_q) + top_ofs;
	assign d_bottom = d_top + height;

	assign o_left   = XW'(o_obs_x);
	assign o_right  = o_left + XW'(`OBS_W);
	assign o_top    = YW'(obs_y_q);
	assign o_bottom = o_top + YW'(`OBS_H);

	// Inclusive overlap on both axes
	assign o_hit = (d_right >= o_left) && (d_left <= o_right) &&
		(d_bottom >= o_top) && (d_top <= o_bottom);

endmodule

`default_nettype wire

//--- cmd_decoder.sv
`timescale 1ns/1ns
`default_nettype none
`include "dino_cfg.svh"

module cmd_decoder import dino_pkg::*; (
	input  wire      Clock,
	input  wire      rst_n,
	input  wire      i_valid,
	input  rx_byte_t i_byte,
	output logic     o_jump,
	output logic     o_ducking
);

	localparam int DUCK_W = $clog2(`DUCK_CYCLES);

	logic [DUCK_W-1:0] duck_cnt; // Cycles left after the current one
	logic              is_jump, is_duck;

	assign is_jump = i_valid && (i_byte == CMD_JUMP);
	assign is_duck = i_valid && (i_byte == CMD_DUCK);

	always_ff @(posedge Clock) begin
		if (!rst_n)
			o_jump <= 1'b0;
		else
			o_jump <= is_jump; // One clock wide
	end

	// Duck timer, a second "D" is dropped while it runs
	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			o_ducking <= 1'b0;
			duck_cnt  <= '0;
		end else if (!o_ducking) begin
			if (is_duck) begin
				o_ducking <= 1'b1;
				duck_cnt  <= DUCK_W'(`DUCK_CYCLES - 1);
			end
		end else if (duck_cnt == '0) begin
			o_ducking <= 1'b0;
		end else begin
			duck_cnt <= duck_cnt - 1'b1;
		end
	end

	// Jump only follows a received byte
	a_jump_after_byte: assert property (@(posedge Clock) disable iff (!rst_n)
		o_jump |-> $past(i_valid));

endmodule

`default_nettype wire

//--- uart_rx_16x.sv
`timescale 1ns/1ns
`default_nettype none
`include "dino_cfg.svh"

module uart_rx_16x import dino_pkg::*; (
	input  wire      Clock,
	input  wire      rst_n,
	input  wire      i_rx,
	output logic     o_valid,
	output rx_byte_t o_byte
);

	localparam int DIV_W = (`OS_DIV > 1) ? $clog2(`OS_DIV) : 1;
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`OS_DIV - 1);

	logic [DIV_W-1:0] div_cnt;
	logic             os_tick;
	logic             rx_meta, rx_sync;
	rx_state_t        state;
	logic [3:0]       os_cnt;   // Ticks left to the next sample point
	logic [2:0]       bit_idx;
	rx_byte_t         shift_reg;
	logic             sample;

	// Oversampling tick, one clock wide
	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			div_cnt <= '0;
			os_tick <= 1'b0;
		end else begin
			os_tick <= 1'b0;
			if (div_cnt == DIV_LAST) begin
				div_cnt <= '0;
				os_tick <= 1'b1;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	// Two-flop synchronizer, line idles high
	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= i_rx;
			rx_sync <= rx_meta;
		end
	end

	assign sample = os_tick && (os_cnt == 4'd0);

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			state   <= RX_IDLE;
			os_cnt  <= 4'd0;
			bit_idx <= 3'd0;
			o_valid <= 1'b0;
		end else begin
			o_valid <= 1'b0;
			if (os_tick) begin
				case (state)
					RX_IDLE: if (!rx_sync) begin
						state  <= RX_START;
						os_cnt <= 4'd7; // Half a bit to the middle of start
					end
					RX_START: if (os_cnt == 4'd0) begin
						if (!rx_sync) begin
							state   <= RX_DATA;
							os_cnt  <= 4'd15;
							bit_idx <= 3'd0;
						end else begin
							state <= RX_IDLE; // Glitch, not a start bit
						end
					end else begin
						os_cnt <= os_cnt - 1'b1;
					end
					RX_DATA: if (os_cnt == 4'd0) begin
						os_cnt <= 4'd15;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
						else
							bit_idx <= bit_idx + 1'b1;
					end else begin
						os_cnt <= os_cnt - 1'b1;
					end
					RX_STOP: if (os_cnt == 4'd0) begin
						o_valid <= rx_sync; // Drop frames with a low stop bit
						state   <= RX_IDLE;
					end else begin
						os_cnt <= os_cnt - 1'b1;
					end
					default: state <= RX_IDLE;
				endcase
			end
		end
	end

	// Data path, LSB arrives first
	always_ff @(posedge Clock) begin
		if (sample && state == RX_DATA)
			shift_reg <= {rx_sync, shift_reg[7:1]};
		if (sample && state == RX_STOP)
			o_byte <= shift_reg;
	end

	// A frame takes many ticks, so strobes never come back to back
	a_valid_single: assert property (@(posedge Clock) disable iff (!rst_n)
		o_valid |=> !o_valid);

endmodule

`default_nettype wire

//--- dino_pkg.sv
`default_nettype none

package dino_pkg;

	// Positions on the 320x240 field
	typedef logic [8:0] coord_x_t;
	typedef logic [7:0] coord_y_t;

	// Game counters
	typedef logic [15:0] score_t;
	typedef logic [7:0]  speed_t;

	// Display
	typedef logic [3:0] digit_t; // One decimal digit
	typedef logic [6:0] seg7_t;  // Active low, g is bit 6

	// Serial command path
	typedef logic [7:0] rx_byte_t;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	// ASCII command codes
	localparam rx_byte_t CMD_JUMP = 8'h4A; // "J"
	localparam rx_byte_t CMD_DUCK = 8'h44; // "D"

endpackage

`default_nettype wire

//--- dino_cfg.svh
`ifndef DINO_CFG_SVH
`define DINO_CFG_SVH

// Playfield
`define XSCREEN         320 // Obstacle x after restart

// Pass flag re-arm window, obstacle wrapped from left edge to right edge
`define SCORE_REARM_HI  250
`define SCORE_REARM_LO  50

// Dinosaur hitbox in x
`define DINO_X_OFS      6
`define DINO_W          20

// Dinosaur hitbox in y, standing and ducking
`define DINO_TOP_STAND  2
`define DINO_H_STAND    28
`define DINO_TOP_DUCK   16 // Head drops while ducking
`define DINO_H_DUCK     16

// Obstacle box
`define OBS_W           16
`define OBS_H           16

// Serial receiver and commands
`define OS_DIV          4   // Clocks per 16x oversampling tick
`define DUCK_CYCLES     200 // Duck length in clocks

`endif
